// ==== source/kitchen_pkg.sv ====
package kitchen_pkg;

    // item code on one counter space
    typedef logic [3:0] item_t;

    // remaining seconds of one open order
    typedef logic [4:0] seconds_t;

    // running score, unsigned
    typedef logic [9:0] points_t;

    localparam int ORDER_SLOTS = 4;

    // occupied order slots, oldest order in bit 0
    typedef logic [ORDER_SLOTS-1:0] slot_mask_t;

    // finished dish as it appears on the delivery space
    localparam item_t DISH_READY = 4'd4;

    // order timing in game seconds
    localparam seconds_t ORDER_LIFETIME = 5'd30;
    localparam seconds_t ARRIVAL_SECONDS = 5'd20;

    // board clock cycles per game second
    localparam int SECOND_CYCLES = 21_000_000;

    localparam points_t SERVE_POINTS = 10'd20;
    localparam points_t EXPIRE_PENALTY = 10'd10;

    // freshness thresholds, checked with a strict greater-than
    localparam seconds_t BONUS_HIGH = 5'd15;
    localparam seconds_t BONUS_MID = 5'd10;
    localparam seconds_t BONUS_LOW = 5'd5;

    localparam points_t BONUS_HIGH_POINTS = 10'd6;
    localparam points_t BONUS_MID_POINTS = 10'd4;
    localparam points_t BONUS_LOW_POINTS = 10'd2;

    typedef enum logic [1:0] {
        STOPPED,
        EMPTY,
        ACTIVE
    } control_state_t;

endpackage

// ==== source/second_tick.sv ====
`timescale 1ns/1ps

module second_tick #(
    parameter int second_cycles = kitchen_pkg::SECOND_CYCLES
) (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic arrival_clear,
    output logic sec_pulse,
    output logic arrival_due
);

    localparam int COUNT_BITS = (second_cycles > 1) ? $clog2(second_cycles) : 1;

    logic [COUNT_BITS-1:0] cycle_count;
    logic second_done;
    kitchen_pkg::seconds_t arrival_count;

    // last cycle of the current game second
    assign second_done = enable && (cycle_count == COUNT_BITS'(second_cycles - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            cycle_count <= '0;
            sec_pulse <= 1'b0;
        end else begin
            sec_pulse <= second_done;
            // prescaler holds its place while the game is paused
            if (enable) begin
                cycle_count <= second_done ? '0 : cycle_count + 1'b1;
            end
        end
    end

    // seconds since the last arrival, parked at the arrival interval
    always_ff @(posedge clock) begin
        if (reset) begin
            arrival_count <= '0;
        end else if (arrival_clear) begin
            arrival_count <= '0;
        end else if (sec_pulse && arrival_count != kitchen_pkg::ARRIVAL_SECONDS) begin
            arrival_count <= arrival_count + 1'b1;
        end
    end

    assign arrival_due = (arrival_count == kitchen_pkg::ARRIVAL_SECONDS);

    // a second only ends on a cycle where the game was running
    pulse_needs_enable: assert property (@(posedge clock) disable iff (reset)
        $rose(sec_pulse) |-> $past(enable));

endmodule

// ==== source/order_queue.sv ====
`timescale 1ns/1ps

module order_queue (
    input  logic clock,
    input  logic reset,
    input  logic sec_pulse,
    input  logic serve,
    input  logic expire,
    input  logic add_order,
    output kitchen_pkg::slot_mask_t orders,
    output kitchen_pkg::seconds_t [kitchen_pkg::ORDER_SLOTS-1:0] order_times,
    output kitchen_pkg::seconds_t oldest_time,
    output logic oldest_expired,
    output logic full
);

    localparam int SLOTS = kitchen_pkg::ORDER_SLOTS;

    kitchen_pkg::slot_mask_t mask;
    kitchen_pkg::slot_mask_t next_mask;
    kitchen_pkg::slot_mask_t count_mask;
    kitchen_pkg::seconds_t [SLOTS-1:0] times;
    kitchen_pkg::seconds_t [SLOTS-1:0] next_times;
    logic pop;

    assign pop = serve | expire;

    always_comb begin
        next_mask = mask;
        next_times = times;
        // slots that keep counting this cycle, after any shift
        count_mask = mask;

        if (pop) begin
            next_mask = mask >> 1;
            next_times = {kitchen_pkg::ORDER_LIFETIME, times[SLOTS-1:1]};
            count_mask = mask >> 1;
        end else if (add_order && !mask[SLOTS-1]) begin
            // occupancy is contiguous, so the new bit lands just above the run
            next_mask = {mask[SLOTS-2:0], 1'b1};
            for (int i = 0; i < SLOTS; i++) begin
                if (next_mask[i] && !mask[i]) begin
                    next_times[i] = kitchen_pkg::ORDER_LIFETIME;
                end
            end
        end

        // the new order is not counted down on its first cycle
        if (sec_pulse) begin
            for (int i = 0; i < SLOTS; i++) begin
                if (count_mask[i] && next_times[i] != '0) begin
                    next_times[i] = next_times[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mask <= '0;
            times <= {SLOTS{kitchen_pkg::ORDER_LIFETIME}};
        end else begin
            mask <= next_mask;
            times <= next_times;
        end
    end

    assign orders = mask;
    assign order_times = times;
    assign oldest_time = times[0];
    assign oldest_expired = mask[0] && (times[0] == '0);
    assign full = mask[SLOTS-1];

    // open orders always fill the queue from the oldest slot up
    mask_contiguous: assert property (@(posedge clock) disable iff (reset)
        (mask & kitchen_pkg::slot_mask_t'(mask + 1'b1)) == '0);

    // the controller issues one game event at a time
    one_event: assert property (@(posedge clock) disable iff (reset)
        $onehot0({serve, expire, add_order}));

endmodule

// ==== source/score_keeper.sv ====
`timescale 1ns/1ps

module score_keeper (
    input  logic clock,
    input  logic reset,
    input  logic serve,
    input  logic expire,
    input  kitchen_pkg::seconds_t oldest_time,
    output kitchen_pkg::points_t point_total
);

    localparam int POINT_BITS = $bits(kitchen_pkg::points_t);

    kitchen_pkg::points_t bonus;
    // one extra bit to catch overflow of the addition
    logic [POINT_BITS:0] serve_sum;

    // freshness bonus from the served order's remaining seconds
    always_comb begin
        if (oldest_time > kitchen_pkg::BONUS_HIGH) begin
            bonus = kitchen_pkg::BONUS_HIGH_POINTS;
        end else if (oldest_time > kitchen_pkg::BONUS_MID) begin
            bonus = kitchen_pkg::BONUS_MID_POINTS;
        end else if (oldest_time > kitchen_pkg::BONUS_LOW) begin
            bonus = kitchen_pkg::BONUS_LOW_POINTS;
        end else begin
            bonus = '0;
        end
    end

    assign serve_sum = {1'b0, point_total}
                     + {1'b0, kitchen_pkg::SERVE_POINTS}
                     + {1'b0, bonus};

    always_ff @(posedge clock) begin
        if (reset) begin
            point_total <= '0;
        end else if (serve) begin
            // saturate at the top of the score range
            if (serve_sum[POINT_BITS]) begin
                point_total <= '1;
            end else begin
                point_total <= serve_sum[POINT_BITS-1:0];
            end
        end else if (expire) begin
            // floor at zero instead of wrapping
            if (point_total < kitchen_pkg::EXPIRE_PENALTY) begin
                point_total <= '0;
            end else begin
                point_total <= point_total - kitchen_pkg::EXPIRE_PENALTY;
            end
        end
    end

endmodule

// ==== source/service_control.sv ====
`timescale 1ns/1ps

module service_control (
    input  logic clock,
    input  logic reset,
    input  logic timer_go,
    input  kitchen_pkg::item_t [1:0] check_spaces,
    input  kitchen_pkg::slot_mask_t orders,
    input  logic full,
    input  logic oldest_expired,
    input  logic arrival_due,
    output logic serve,
    output logic expire,
    output logic add_order,
    output logic arrival_clear,
    output kitchen_pkg::item_t [1:0] out_spaces
);

    kitchen_pkg::control_state_t state;
    kitchen_pkg::control_state_t next_state;
    logic busy;
    logic dish_ready;
    logic last_order;
    logic serve_next;
    logic expire_next;
    logic add_next;

    // an event is in flight until the queue has taken it
    assign busy = serve | expire | add_order;
    assign dish_ready = (check_spaces[1] == kitchen_pkg::DISH_READY);
    // popping this order leaves the queue empty
    assign last_order = !orders[1];

    always_comb begin
        next_state = state;
        serve_next = 1'b0;
        expire_next = 1'b0;
        add_next = 1'b0;

        case (state)
            kitchen_pkg::STOPPED: begin
                if (timer_go) begin
                    next_state = orders[0] ? kitchen_pkg::ACTIVE : kitchen_pkg::EMPTY;
                end
            end
            kitchen_pkg::EMPTY: begin
                if (!timer_go) begin
                    next_state = kitchen_pkg::STOPPED;
                end else if (!busy) begin
                    // nothing open, so the first order arrives right away
                    add_next = 1'b1;
                    next_state = kitchen_pkg::ACTIVE;
                end
            end
            kitchen_pkg::ACTIVE: begin
                if (!timer_go) begin
                    next_state = kitchen_pkg::STOPPED;
                end else if (!busy) begin
                    // serve beats expire beats arrival
                    if (dish_ready && orders[0]) begin
                        serve_next = 1'b1;
                        next_state = last_order ? kitchen_pkg::EMPTY : kitchen_pkg::ACTIVE;
                    end else if (oldest_expired) begin
                        expire_next = 1'b1;
                        next_state = last_order ? kitchen_pkg::EMPTY : kitchen_pkg::ACTIVE;
                    end else if (arrival_due && !full) begin
                        add_next = 1'b1;
                    end
                end
            end
            default: begin
                next_state = kitchen_pkg::STOPPED;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= kitchen_pkg::STOPPED;
            serve <= 1'b0;
            expire <= 1'b0;
            add_order <= 1'b0;
            out_spaces <= '0;
        end else begin
            state <= next_state;
            serve <= serve_next;
            expire <= expire_next;
            add_order <= add_next;
            out_spaces <= check_spaces;
            // the served dish leaves the delivery space
            if (serve) begin
                out_spaces[1] <= '0;
            end
        end
    end

    // a new order restarts the arrival interval
    assign arrival_clear = add_order;

    // a serve reaches the queue while the order it pops is still open
    serve_from_active: assert property (@(posedge clock) disable iff (reset)
        serve |-> orders[0] && $past(state) == kitchen_pkg::ACTIVE);

endmodule

// ==== source/kitchen_orders_top.sv ====
`timescale 1ns/1ps

module kitchen_orders_top #(
    parameter int second_cycles = kitchen_pkg::SECOND_CYCLES
) (
    input  logic clock,
    input  logic reset,
    input  logic timer_go,
    input  kitchen_pkg::item_t [1:0] check_spaces,
    output kitchen_pkg::item_t [1:0] out_spaces,
    output kitchen_pkg::points_t point_total,
    output kitchen_pkg::slot_mask_t orders,
    output kitchen_pkg::seconds_t [kitchen_pkg::ORDER_SLOTS-1:0] order_times
);

    logic sec_pulse;
    logic arrival_due;
    logic arrival_clear;
    logic serve;
    logic expire;
    logic add_order;
    logic full;
    logic oldest_expired;
    kitchen_pkg::seconds_t oldest_time;

    second_tick #(
        .second_cycles(second_cycles)
    ) second_tick_inst (
        .clock(clock),
        .reset(reset),
        .enable(timer_go),
        .arrival_clear(arrival_clear),
        .sec_pulse(sec_pulse),
        .arrival_due(arrival_due)
    );

    order_queue order_queue_inst (
        .clock(clock),
        .reset(reset),
        .sec_pulse(sec_pulse),
        .serve(serve),
        .expire(expire),
        .add_order(add_order),
        .orders(orders),
        .order_times(order_times),
        .oldest_time(oldest_time),
        .oldest_expired(oldest_expired),
        .full(full)
    );

    score_keeper score_keeper_inst (
        .clock(clock),
        .reset(reset),
        .serve(serve),
        .expire(expire),
        .oldest_time(oldest_time),
        .point_total(point_total)
    );

    service_control service_control_inst (
        .clock(clock),
        .reset(reset),
        .timer_go(timer_go),
        .check_spaces(check_spaces),
        .orders(orders),
        .full(full),
        .oldest_expired(oldest_expired),
        .arrival_due(arrival_due),
        .serve(serve),
        .expire(expire),
        .add_order(add_order),
        .arrival_clear(arrival_clear),
        .out_spaces(out_spaces)
    );

endmodule

// ==== verif/kitchen_orders_tb.sv ====
`timescale 1ns/1ps

module kitchen_orders_tb;

    localparam int HALF_PERIOD = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 4;
    localparam int SIM_SECOND_CYCLES = 4;

    // words per golden line: count, reset, timer_go, space 0, space 1,
    // expected point_total, orders, oldest time, delivery space
    localparam int FIELDS = 9;
    localparam int MAX_LINES = 64;
    localparam int MAX_LINE_CYCLES = 1000;
    localparam string GOLDEN_FILE = "verif/kitchen_orders_golden.txt";

    logic clock;
    logic reset;
    logic timer_go;
    kitchen_pkg::item_t [1:0] check_spaces;
    kitchen_pkg::item_t [1:0] out_spaces;
    kitchen_pkg::points_t point_total;
    kitchen_pkg::slot_mask_t orders;
    kitchen_pkg::seconds_t [kitchen_pkg::ORDER_SLOTS-1:0] order_times;

    logic [15:0] golden [0:FIELDS*MAX_LINES-1];
    int errors;

    kitchen_orders_top #(
        .second_cycles(SIM_SECOND_CYCLES)
    ) kitchen_orders_top_inst (
        .clock(clock),
        .reset(reset),
        .timer_go(timer_go),
        .check_spaces(check_spaces),
        .out_spaces(out_spaces),
        .point_total(point_total),
        .orders(orders),
        .order_times(order_times)
    );

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // empty slots hold a fresh countdown, and younger orders never run out first
    task automatic check_slot_times;
        for (int i = 0; i < kitchen_pkg::ORDER_SLOTS; i++) begin
            if (!orders[i]) begin
                compare_value($sformatf("order_times[%0d]", i), order_times[i],
                              kitchen_pkg::ORDER_LIFETIME);
            end else if (i > 0 && order_times[i] < order_times[i-1]) begin
                errors++;
                $display("at %0t order slot %0d has less time left than the older slot %0d",
                         $time, i, i - 1);
            end
        end
    endtask

    // drive one golden line, hold it for its cycle count, then check
    task automatic apply_line(input int base);
        int cycles;
        cycles = golden[base];
        reset = golden[base+1][0];
        timer_go = golden[base+2][0];
        check_spaces[0] = golden[base+3][3:0];
        check_spaces[1] = golden[base+4][3:0];
        if (cycles > MAX_LINE_CYCLES) begin
            errors++;
            $display("golden line at word %0d asks for too many cycles (%0d)", base, cycles);
            cycles = MAX_LINE_CYCLES;
        end
        repeat (cycles) begin
            @(posedge clock);
            #(DRIVE_DELAY);
        end
        compare_value("point_total", point_total, golden[base+5]);
        compare_value("orders", orders, golden[base+6]);
        compare_value("order_times[0]", order_times[0], golden[base+7]);
        compare_value("out_spaces[1]", out_spaces[1], golden[base+8]);
        // prep space passes straight through
        compare_value("out_spaces[0]", out_spaces[0], check_spaces[0]);
        check_slot_times();
    endtask

    // walk the golden lines until the zero-count end marker
    task automatic run_golden_lines;
        int line;
        int base;
        bit done;
        line = 0;
        done = 1'b0;
        while (!done && line < MAX_LINES) begin
            base = line * FIELDS;
            if ($isunknown(golden[base]) || golden[base] == 16'd0) begin
                done = 1'b1;
            end else begin
                apply_line(base);
                line++;
            end
        end
        if (!done) begin
            errors++;
            $display("golden file has no end marker within %0d lines", MAX_LINES);
        end
        if (line == 0) begin
            errors++;
            $display("golden file holds no stimulus lines");
        end
    endtask

    initial begin
        int fd;
        errors = 0;
        reset = 1'b1;
        timer_go = 1'b0;
        check_spaces = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        reset = 1'b0;

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the golden file %s", GOLDEN_FILE);
        end else begin
            $fclose(fd);
            $readmemh(GOLDEN_FILE, golden);
            run_golden_lines();
        end

        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/kitchen_orders_golden.txt ====
// columns, all hex: cycles reset timer_go space0 space1
//   expected: point_total orders oldest_time out_space1 (zero cycles ends the file)
// stopped after reset, then the first order opens at once
0003 0 0 0 0 000 0 1e 0
0003 0 1 1 0 000 1 1e 0
// fresh serve adds 26 and clears the delivery space
0001 0 1 1 4 000 1 1e 4
0001 0 1 1 4 01a 0 1e 0
// next order opens, serve at 12 seconds for 24
0049 0 1 3 0 01a 1 0c 0
0001 0 1 3 4 01a 1 0c 4
0001 0 1 3 0 032 0 1e 0
0002 0 1 3 0 032 1 1e 0
// second order arrives after 20 seconds
0051 0 1 5 0 032 3 0a 0
// serve at 7 seconds for 22
000a 0 1 5 0 032 3 07 0
0001 0 1 5 4 032 3 07 4
0001 0 1 5 0 048 1 1b 0
// serve at 3 seconds for 20
005e 0 1 6 0 048 3 03 0
0001 0 1 6 4 048 3 03 4
0001 0 1 6 0 05c 1 17 0
// oldest order runs out, 10 points off
005a 0 1 7 0 05c 3 00 0
0002 0 1 7 0 052 1 14 0
// paused, dish on space 1 is ignored
0008 0 0 2 4 052 1 14 4
0002 0 1 2 0 052 1 13 0
// fresh start for the penalty floor
0004 1 0 0 0 000 0 1e 0
0003 0 1 8 0 000 1 1e 0
0050 0 1 8 0 000 3 0a 0
0026 0 1 9 0 000 3 00 0
0002 0 1 9 0 000 1 14 0
// end marker
0000 0 0 0 0 000 0 00 0

// ==== src.f ====
source/kitchen_pkg.sv
source/second_tick.sv
source/order_queue.sv
source/score_keeper.sv
source/service_control.sv
source/kitchen_orders_top.sv
verif/kitchen_orders_tb.sv

// ==== Makefile ====
# Verilator flow for the kitchen order block

VERILATOR ?= verilator
TOP       ?= kitchen_orders_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(BINARY)
	./$(BINARY) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation gave no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
